// ==== Makefile ====
# Verilator build and run of the SDRAM command front end testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module sdram_ctrl_tb -Mdir obj_dir -f src.f

run: compile
	./obj_dir/Vsdram_ctrl_tb | tee $(LOG)
	@if grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/sdram_ctrl_tb.sv ====
/*
 * Testbench for the SDRAM command front end
 * Test cases from the testdata file, enable pulses and pin decoding
 * Checks command order, spacing, addresses, counts and the ready level
 */
`default_nettype none

module sdram_ctrl_tb;

    localparam int PERIOD   = 100;
    localparam int PWR      = int'(sdram_timing_pkg::POWER_UP_CYCLES);
    localparam int TRP      = int'(sdram_timing_pkg::TRP_CYCLES);
    localparam int TRC      = int'(sdram_timing_pkg::TRC_CYCLES);
    localparam int TMRD     = int'(sdram_timing_pkg::TMRD_CYCLES);
    localparam int INIT_REF = int'(sdram_timing_pkg::INIT_REFRESH_COUNT);
    localparam int INTERVAL = int'(sdram_timing_pkg::REFRESH_INTERVAL);

    logic        clock;
    logic        reset;
    logic        enable;
    logic        ready;
    logic        dram_cs_n;
    logic        dram_ras_n;
    logic        dram_cas_n;
    logic        dram_we_n;
    logic [12:0] dram_addr;
    logic [1:0]  dram_ba;

    // One entry per test case
    int          delay_q[$];
    int          run_q[$];
    int          second_q[$];    // Second enable cycle or 0 for none
    int          pre_q[$];
    int          ref_q[$];
    int          mrs_q[$];
    logic [12:0] mode_q[$];

    int          error_count;
    int          failed_tests;
    int          seed;
    int          watchdog_cycles;

    // Per-test tracking in cycles from the enable pulse
    int          cmd_idx;        // Commands seen so far
    int          last_cmd_t;
    int          mode_t;         // MODE SET time on the pins or -1
    int          last_per_t;     // Latest periodic refresh or -1
    int          n_pre;
    int          n_ref;
    int          n_mrs;
    logic [12:0] exp_mode;

    sdram_ctrl_top dut (
        .clock      (clock),
        .reset      (reset),
        .enable     (enable),
        .ready      (ready),
        .dram_cs_n  (dram_cs_n),
        .dram_ras_n (dram_ras_n),
        .dram_cas_n (dram_cas_n),
        .dram_we_n  (dram_we_n),
        .dram_addr  (dram_addr),
        .dram_ba    (dram_ba)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic load_tests;
        int               fd;
        int               code;
        int               lines;
        int               d;
        int               r;
        int               s;
        int               p;
        int               a;
        int               m;
        int               total;
        logic [12:0]      w;
        logic [8*200-1:0] skip_line;
        total = 50;                                         // Startup margin
        fd = $fopen("dv/sdram_testdata.txt", "r");
        if (fd == 0) begin
            $display("Error: could not open dv/sdram_testdata.txt");
            error_count++;
        end else begin
            for (lines = 0; lines < 200 && !$feof(fd); lines++) begin
                code = $fscanf(fd, " %d %d %d %d %d %d %h", d, r, s, p, a, m, w);
                if (code == 7) begin
                    delay_q.push_back(d);
                    run_q.push_back(r);
                    second_q.push_back(s);
                    pre_q.push_back(p);
                    ref_q.push_back(a);
                    mrs_q.push_back(m);
                    mode_q.push_back(w);
                    total += d + 8 + r + 4 + 10;            // Random delay below 8
                end else if (!$feof(fd)) begin
                    code = $fgets(skip_line, fd);           // Comment line
                end
            end
            $fclose(fd);
        end
        watchdog_cycles = total;
    endtask

    task automatic apply_reset;
        @(negedge clock);
        reset  = 1'b1;
        enable = 1'b0;
        repeat (2) @(negedge clock);
        reset = 1'b0;
    endtask

    // Order and spacing of every non-NOP command on the pins
    task automatic check_command_order(input int t, input logic [3:0] code);
        logic [3:0] exp_code;
        int         exp_gap;
        if (cmd_idx == 0)
            exp_code = sdram_cmd_pkg::CMD_PRECHARGE;
        else if (cmd_idx <= INIT_REF)
            exp_code = sdram_cmd_pkg::CMD_AUTO_REFRESH;
        else if (cmd_idx == INIT_REF + 1)
            exp_code = sdram_cmd_pkg::CMD_MODE_SET;
        else
            exp_code = sdram_cmd_pkg::CMD_AUTO_REFRESH;    // Periodic
        check_value(32'(code), 32'(exp_code), "command out of order");
        if (cmd_idx == 0)
            exp_gap = PWR + 2;                              // Power-up plus enable edge and pin register
        else if (cmd_idx == 1)
            exp_gap = TRP + 1;
        else if (cmd_idx <= INIT_REF + 1)
            exp_gap = TRC + 1;
        else if (cmd_idx == INIT_REF + 2)
            exp_gap = TMRD - 1 + INTERVAL;                  // init_done is the last TMRD cycle
        else
            exp_gap = INTERVAL;
        check_value(t - last_cmd_t, exp_gap, "command spacing");
        if (code == sdram_cmd_pkg::CMD_MODE_SET)
            mode_t = t;
        if (cmd_idx > INIT_REF + 1)
            last_per_t = t;
        last_cmd_t = t;
        cmd_idx++;
    endtask

    task automatic check_sample(input int t);
        logic [3:0] code;
        logic       exp_ready;
        code = {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n};
        check_value(32'(dram_ba), 32'd0, "bank pins not zero");
        case (code)
            sdram_cmd_pkg::CMD_NOP:
                check_value(32'(dram_addr), 32'd0, "address not zero during NOP");
            sdram_cmd_pkg::CMD_PRECHARGE: begin
                check_command_order(t, code);
                check_value(32'(dram_addr[10]), 32'd1, "A10 low during PRECHARGE");
                n_pre++;
            end
            sdram_cmd_pkg::CMD_AUTO_REFRESH: begin
                check_command_order(t, code);
                check_value(32'(dram_addr), 32'd0, "address not zero during AUTO REFRESH");
                n_ref++;
            end
            sdram_cmd_pkg::CMD_MODE_SET: begin
                check_command_order(t, code);
                check_value(32'(dram_addr), 32'(exp_mode), "mode word");
                n_mrs++;
            end
            default: begin
                $display("Error at time %0t: pins carry unknown command code %b", $time, code);
                error_count++;
            end
        endcase
        // High from TMRD cycles after MODE SET except during each refresh and its tRC
        if (mode_t < 0 || t < mode_t + TMRD)
            exp_ready = 1'b0;
        else if (last_per_t >= 0 && t <= last_per_t + TRC)
            exp_ready = 1'b0;
        else
            exp_ready = 1'b1;
        check_value(32'(ready), 32'(exp_ready), "ready level");
    endtask

    task automatic run_test(input int idx);
        int extra;
        int errors_before;
        int t;
        extra         = int'($unsigned($random(seed)) % 32'd8);
        errors_before = error_count;
        cmd_idx       = 0;
        last_cmd_t    = 0;
        mode_t        = -1;
        last_per_t    = -1;
        n_pre         = 0;
        n_ref         = 0;
        n_mrs         = 0;
        exp_mode      = mode_q[idx];
        apply_reset();
        // Samples up to t = 0 are idle and enable rises right after the t = 0 sample
        for (t = -(delay_q[idx] + extra); t <= run_q[idx]; t++) begin
            @(negedge clock);
            check_sample(t);
            enable = (t == 0) || (second_q[idx] > 0 && t == second_q[idx]);
        end
        enable = 1'b0;
        check_value(n_pre, pre_q[idx], "PRECHARGE count");
        check_value(n_ref, ref_q[idx], "AUTO REFRESH count");
        check_value(n_mrs, mrs_q[idx], "MODE SET count");
        $display("Test %0d: delay %0d, run %0d, second enable %0d, %0d errors",
                 idx, delay_q[idx] + extra, run_q[idx], second_q[idx],
                 error_count - errors_before);
        if (error_count != errors_before)
            failed_tests++;
    endtask

    // Watchdog sized from the test lengths
    initial begin
        wait (watchdog_cycles > 0);
        #(watchdog_cycles * PERIOD);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset           = 1'b1;
        enable          = 1'b0;
        seed            = 32'h4f49_9712;
        error_count     = 0;
        failed_tests    = 0;
        watchdog_cycles = 0;
        load_tests();
        if (delay_q.size() == 0) begin
            $display("Error: no test cases were read");
            error_count++;
        end
        for (int i = 0; i < delay_q.size(); i++)
            run_test(i);
        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 delay_q.size(), failed_tests, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/sdram_testdata.txt ====
# delay run second_enable precharges refreshes mode_sets mode_word(hex)
# run and second_enable count cycles from the enable pulse, second_enable 0 means none
0 7 0 0 0 0 0230
4 8 0 1 0 0 0230
0 60 0 1 6 0 0230
3 90 0 1 8 1 0230
6 85 40 1 8 1 0230
1 183 0 1 8 1 0230
7 184 0 1 9 1 0230
5 200 0 1 9 1 0230
12 192 186 1 9 1 0230
0 283 0 1 9 1 0230
9 284 0 1 10 1 0230
0 300 100 1 10 1 0230
2 400 150 1 11 1 0230
10 500 300 1 12 1 0230

// ==== src.f ====
src/sdram_timing_pkg.sv
src/sdram_cmd_pkg.sv
src/sdram_init_seq.sv
src/sdram_refresh_sched.sv
src/sdram_cmd_mux.sv
src/sdram_ctrl_top.sv
dv/sdram_ctrl_tb.sv

// ==== src/sdram_cmd_mux.sv ====
/*
 * Command source select between init FSM and refresh scheduler
 * Registered SDRAM command, address and bank pins
 * Sticky initialized flag and registered ready level
 */
`default_nettype none

module sdram_cmd_mux (
    input  wire                                     clock,
    input  wire                                     reset,
    input  wire                                     init_active,
    input  wire                                     init_done,
    input  sdram_cmd_pkg::sdram_cmd_t               init_cmd,
    input  wire  [sdram_cmd_pkg::ADDR_WIDTH-1:0]    init_addr,
    input  sdram_cmd_pkg::sdram_cmd_t               ref_cmd,
    input  wire                                     ref_busy,
    output logic                                    dram_cs_n,
    output logic                                    dram_ras_n,
    output logic                                    dram_cas_n,
    output logic                                    dram_we_n,
    output logic [sdram_cmd_pkg::ADDR_WIDTH-1:0]    dram_addr,
    output logic [sdram_cmd_pkg::BA_WIDTH-1:0]      dram_ba,
    output logic                                    ready       // Free for read/write engine
);

    sdram_cmd_pkg::sdram_cmd_t cmd_q;   // Registered pin code
    logic                      initialized;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cmd_q       <= sdram_cmd_pkg::CMD_NOP;
            dram_addr   <= '0;
            dram_ba     <= '0;
            initialized <= 1'b0;
            ready       <= 1'b0;
        end else begin
            if (init_active) begin
                cmd_q     <= init_cmd;
                dram_addr <= init_addr;
            end else begin
                cmd_q     <= ref_cmd;
                dram_addr <= '0;                            // Refresh ignores address
            end
            dram_ba <= '0;                                  // No bank use yet
            if (init_done)
                initialized <= 1'b1;
            // init_done included so ready rises the cycle after it
            ready <= (initialized || init_done) && !ref_busy;
        end
    end

    assign {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} = cmd_q;

endmodule

`default_nettype wire

// ==== src/sdram_cmd_pkg.sv ====
/*
 * SDRAM command opcodes as {cs_n, ras_n, cas_n, we_n}
 * Address and bank widths of the board memory
 * Address word for PRECHARGE ALL
 */
`default_nettype none

package sdram_cmd_pkg;

    localparam int ADDR_WIDTH = 13;     // A12..A0
    localparam int BA_WIDTH   = 2;      // BA1..BA0

    // Pin code, MSB is chip select
    typedef enum logic [3:0] {
        CMD_MODE_SET     = 4'b0000,     // LOAD MODE REGISTER
        CMD_AUTO_REFRESH = 4'b0001,     // CBR refresh, bank ignored
        CMD_PRECHARGE    = 4'b0010,     // A10 selects all banks
        CMD_NOP          = 4'b0111      // Selected, no operation
    } sdram_cmd_t;

    // A10 high turns PRECHARGE into PRECHARGE ALL
    localparam logic [ADDR_WIDTH-1:0] PALL_ADDR = 13'b0_0100_0000_0000;

endpackage

`default_nettype wire

// ==== src/sdram_ctrl_top.sv ====
/*
 * SDRAM command front end top level
 * Init FSM and refresh scheduler feeding the pin multiplexer
 */
`default_nettype none

module sdram_ctrl_top (
    input  wire                                     clock,
    input  wire                                     reset,
    input  wire                                     enable,     // Start initialization
    output logic                                    ready,
    output logic                                    dram_cs_n,
    output logic                                    dram_ras_n,
    output logic                                    dram_cas_n,
    output logic                                    dram_we_n,
    output logic [sdram_cmd_pkg::ADDR_WIDTH-1:0]    dram_addr,
    output logic [sdram_cmd_pkg::BA_WIDTH-1:0]      dram_ba
);

    sdram_cmd_pkg::sdram_cmd_t                init_cmd;
    logic [sdram_cmd_pkg::ADDR_WIDTH-1:0]     init_addr;
    logic                                     init_active;
    logic                                     init_done;    // Arms refresh, sets initialized
    sdram_cmd_pkg::sdram_cmd_t                ref_cmd;
    logic                                     ref_busy;

    sdram_init_seq u_init_seq (
        .clock       (clock),
        .reset       (reset),
        .enable      (enable),
        .init_cmd    (init_cmd),
        .init_addr   (init_addr),
        .init_active (init_active),
        .init_done   (init_done)
    );

    sdram_refresh_sched u_refresh_sched (
        .clock     (clock),
        .reset     (reset),
        .init_done (init_done),
        .ref_cmd   (ref_cmd),
        .ref_busy  (ref_busy)
    );

    sdram_cmd_mux u_cmd_mux (
        .clock       (clock),
        .reset       (reset),
        .init_active (init_active),
        .init_done   (init_done),
        .init_cmd    (init_cmd),
        .init_addr   (init_addr),
        .ref_cmd     (ref_cmd),
        .ref_busy    (ref_busy),
        .dram_cs_n   (dram_cs_n),
        .dram_ras_n  (dram_ras_n),
        .dram_cas_n  (dram_cas_n),
        .dram_we_n   (dram_we_n),
        .dram_addr   (dram_addr),
        .dram_ba     (dram_ba),
        .ready       (ready)
    );

endmodule

`default_nettype wire

// ==== src/sdram_init_seq.sv ====
/*
 * SDRAM power-up and initialization FSM
 * Power-up wait, PRECHARGE ALL, eight AUTO REFRESH, MODE SET
 * Internal wait counter and refresh counter
 */
`default_nettype none

module sdram_init_seq (
    input  wire                                     clock,
    input  wire                                     reset,
    input  wire                                     enable,      // Start request
    output sdram_cmd_pkg::sdram_cmd_t               init_cmd,    // Wanted command
    output logic [sdram_cmd_pkg::ADDR_WIDTH-1:0]    init_addr,   // Wanted address
    output logic                                    init_active, // Sequence owns the pins
    output logic                                    init_done    // Last TMRD cycle
);

    typedef enum logic [3:0] {
        IDLE,
        POWER_UP,
        PRECHARGE,
        TRP_WAIT,
        REFRESH,
        TRC_WAIT,
        MODE_SET,
        TMRD_WAIT,
        DONE
    } state_t;

    state_t state;
    state_t state_next;

    logic [sdram_timing_pkg::COUNT_WIDTH-1:0] wait_cnt;     // Cycles spent in a wait state
    logic [sdram_timing_pkg::COUNT_WIDTH-1:0] wait_target;  // Last cycle of current wait
    logic [sdram_timing_pkg::COUNT_WIDTH-1:0] ref_cnt;      // Init refreshes issued
    logic                                     in_wait;      // Counting NOP cycles
    logic                                     wait_expired;

    // Wait length per state
    always_comb begin
        in_wait     = 1'b1;
        wait_target = '0;
        case (state)
            POWER_UP:  wait_target = sdram_timing_pkg::POWER_UP_CYCLES - 1'b1;
            TRP_WAIT:  wait_target = sdram_timing_pkg::TRP_CYCLES - 1'b1;
            TRC_WAIT:  wait_target = sdram_timing_pkg::TRC_CYCLES - 1'b1;
            TMRD_WAIT: wait_target = sdram_timing_pkg::TMRD_CYCLES - 1'b1;
            default:   in_wait = 1'b0;                      // Single-cycle or holding states
        endcase
    end

    assign wait_expired = (wait_cnt == wait_target);

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (enable) state_next = POWER_UP;
            POWER_UP:  if (wait_expired) state_next = PRECHARGE;
            PRECHARGE: state_next = TRP_WAIT;
            TRP_WAIT:  if (wait_expired) state_next = REFRESH;
            REFRESH:   state_next = TRC_WAIT;
            TRC_WAIT: begin
                if (wait_expired) begin
                    // Count already includes the refresh just issued
                    if (ref_cnt == sdram_timing_pkg::INIT_REFRESH_COUNT)
                        state_next = MODE_SET;
                    else
                        state_next = REFRESH;
                end
            end
            MODE_SET:  state_next = TMRD_WAIT;
            TMRD_WAIT: if (wait_expired) state_next = DONE;
            DONE:      state_next = DONE;                   // Held until reset
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            wait_cnt <= '0;
            ref_cnt  <= '0;
        end else begin
            state <= state_next;
            if (state_next != state)
                wait_cnt <= '0;                             // Fresh count per state
            else if (in_wait)
                wait_cnt <= wait_cnt + 1'b1;
            if (state == REFRESH)
                ref_cnt <= ref_cnt + 1'b1;
        end
    end

    // Command and address per state
    always_comb begin
        init_cmd  = sdram_cmd_pkg::CMD_NOP;
        init_addr = '0;                                     // Don't care outside PALL and MRS
        case (state)
            PRECHARGE: begin
                init_cmd  = sdram_cmd_pkg::CMD_PRECHARGE;
                init_addr = sdram_cmd_pkg::PALL_ADDR;       // All banks
            end
            REFRESH:   init_cmd = sdram_cmd_pkg::CMD_AUTO_REFRESH;
            MODE_SET: begin
                init_cmd  = sdram_cmd_pkg::CMD_MODE_SET;
                init_addr = sdram_timing_pkg::MODE_REG_VALUE;
            end
            default:   init_cmd = sdram_cmd_pkg::CMD_NOP;
        endcase
    end

    assign init_active = (state != IDLE) && (state != DONE);
    assign init_done   = (state == TMRD_WAIT) && wait_expired;  // tMRD met after this cycle

endmodule

`default_nettype wire

// ==== src/sdram_refresh_sched.sv ====
/*
 * Periodic AUTO REFRESH scheduler
 * Armed by the end of initialization, one refresh per interval
 * Busy level covering the refresh and its recovery window
 */
`default_nettype none

module sdram_refresh_sched (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         init_done,  // Arms the interval timer
    output sdram_cmd_pkg::sdram_cmd_t   ref_cmd,    // AUTO REFRESH pulse or NOP
    output logic                        ref_busy    // Refresh plus tRC window
);

    logic                                     armed;        // Init finished
    logic [sdram_timing_pkg::COUNT_WIDTH-1:0] interval_cnt; // Position in refresh period
    logic [sdram_timing_pkg::COUNT_WIDTH-1:0] busy_cnt;     // Recovery cycles left
    logic                                     refresh_due;

    // Expiry one cycle ahead of the pins, the mux adds the other
    assign refresh_due = armed &&
                         (interval_cnt == sdram_timing_pkg::REFRESH_INTERVAL - 1'b1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            armed        <= 1'b0;
            interval_cnt <= '0;
        end else if (!armed) begin
            if (init_done) begin
                armed        <= 1'b1;
                interval_cnt <= 'd1;                        // init_done cycle counts as zero
            end
        end else if (refresh_due) begin
            interval_cnt <= '0;                             // Wrap, next period
        end else begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    // Recovery window after each refresh
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            busy_cnt <= '0;
        else if (refresh_due)
            busy_cnt <= sdram_timing_pkg::TRC_CYCLES;
        else if (busy_cnt != '0)
            busy_cnt <= busy_cnt - 1'b1;
    end

    assign ref_cmd  = refresh_due ? sdram_cmd_pkg::CMD_AUTO_REFRESH : sdram_cmd_pkg::CMD_NOP;
    assign ref_busy = refresh_due || (busy_cnt != '0);

endmodule

`default_nettype wire

// ==== src/sdram_timing_pkg.sv ====
/*
 * SDRAM timing constants in clock cycles
 * Counter width shared by the sequencer and refresh scheduler
 * Mode register word loaded during initialization
 */
`default_nettype none

package sdram_timing_pkg;

    // Wide enough for REFRESH_INTERVAL, the largest count
    localparam int COUNT_WIDTH = 7;

    // Power-up wait before the first command
    localparam logic [COUNT_WIDTH-1:0] POWER_UP_CYCLES = 7'd6;      // Shortened 100 us wait

    localparam logic [COUNT_WIDTH-1:0] TRP_CYCLES = 7'd2;           // NOPs after PRECHARGE
    localparam logic [COUNT_WIDTH-1:0] TRC_CYCLES = 7'd8;           // NOPs after AUTO REFRESH
    localparam logic [COUNT_WIDTH-1:0] INIT_REFRESH_COUNT = 7'd8;   // Refreshes during init
    localparam logic [COUNT_WIDTH-1:0] TMRD_CYCLES = 7'd2;          // NOPs after MODE SET

    // Periodic refresh spacing, command to command
    localparam logic [COUNT_WIDTH-1:0] REFRESH_INTERVAL = 7'd100;

    // Mode register word, driven on the address pins with MODE SET
    localparam logic [12:0] MODE_REG_VALUE = {
        3'b000,     // A12..A10 reserved
        1'b1,       // A9 single location write
        2'b00,      // A8..A7 normal operation
        3'b011,     // A6..A4 CAS latency 3
        1'b0,       // A3 sequential burst
        3'b000      // A2..A0 burst length 1
    };

endpackage

`default_nettype wire
